//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    // **********************************************************************
    // basic machine types
    // **********************************************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam int NUM_REGS = 32;

    // jal writes its return address here
    localparam reg_addr_t LINK_REG = 5'd31;

    // **********************************************************************
    // primary opcodes, inst[31:26]
    // **********************************************************************
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // funct codes under OP_SPECIAL, inst[5:0]
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

endpackage

//--- hdl/id_ctrl_pkg.sv
package id_ctrl_pkg;

    import mips_isa_pkg::*;

    // ALU operation handed to EX; add must stay at zero for bubbles
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC1_RS    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_SHAMT = 2'd2
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RT    = 2'd0,
        SRC2_SIMM  = 2'd1,
        SRC2_EIGHT = 2'd2,
        SRC2_ZIMM  = 2'd3
    } src2_sel_t;

    // pipeline stall vector, id and ex hold bits only
    typedef struct packed {
        logic ex_hold;
        logic id_hold;
    } stall_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        logic      mem_en;
        logic      mem_we;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      rf_from_mem;
    } id_ctrl_t;

endpackage

//--- hdl/fwd_if.sv
`timescale 1ns/1ps

interface fwd_if import mips_isa_pkg::*; ();

    // write-back sources seen by decode
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;

    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;

    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    modport source (
        output ex_we, ex_waddr, ex_wdata,
        output mem_we, mem_waddr, mem_wdata,
        output wb_we, wb_waddr, wb_wdata
    );

    modport sink (
        input ex_we, ex_waddr, ex_wdata,
        input mem_we, mem_waddr, mem_wdata,
        input wb_we, wb_waddr, wb_wdata
    );

    // register file write port
    modport wb_sink (input wb_we, wb_waddr, wb_wdata);

endinterface

//--- hdl/if_id_latch.sv
`timescale 1ns/1ps

module if_id_latch import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  stall_t stall,
    input  logic   if_valid,
    input  word_t  if_pc,
    input  word_t  inst_rdata,
    output logic   id_valid,
    output word_t  id_pc,
    output word_t  inst
);

    // copy of the instruction word taken on the first held cycle
    logic  held;
    word_t held_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid  <= 1'b0;
            id_pc     <= '0;
            held      <= 1'b0;
            held_inst <= '0;
        end else if (!stall.id_hold) begin
            // normal advance
            id_valid <= if_valid;
            id_pc    <= if_pc;
            held     <= 1'b0;
        end else if (!stall.ex_hold) begin
            // id stalls but ex moves on, so insert a bubble
            id_valid <= 1'b0;
            id_pc    <= '0;
            held     <= 1'b0;
        end else if (!held) begin
            // both held, memory output may change under us
            held      <= 1'b1;
            held_inst <= inst_rdata;
        end
    end

    assign inst = held ? held_inst : inst_rdata;

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  word_t     inst,
    input  logic      id_valid,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output id_ctrl_t  ctrl,
    // one-hot {jump, bne, beq}; jump covers j, jal and jr
    output logic [2:0] br_kind
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd_addr;
    id_ctrl_t  dec_ctrl;
    logic      is_beq;
    logic      is_bne;
    logic      is_jump;

    // **********************************************************************
    // field extraction
    // R: op | rs | rt | rd | shamt | funct
    // I: op | rs | rt | imm16
    // J: op | index26
    // **********************************************************************
    assign opcode  = inst[31:26];
    assign rs_addr = inst[25:21];
    assign rt_addr = inst[20:16];
    assign rd_addr = inst[15:11];
    assign funct   = inst[5:0];

    always_comb begin
        // default is add rs, rt with nothing enabled
        dec_ctrl = '0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_jump  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dec_ctrl.rf_we    = 1'b1;
                dec_ctrl.rf_waddr = rd_addr;
                case (funct)
                    FN_ADD, FN_ADDU: dec_ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec_ctrl.alu_op = ALU_SUB;
                    FN_SLT:          dec_ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         dec_ctrl.alu_op = ALU_SLTU;
                    FN_AND:          dec_ctrl.alu_op = ALU_AND;
                    FN_OR:           dec_ctrl.alu_op = ALU_OR;
                    FN_XOR:          dec_ctrl.alu_op = ALU_XOR;
                    FN_NOR:          dec_ctrl.alu_op = ALU_NOR;
                    FN_SLLV:         dec_ctrl.alu_op = ALU_SLL;
                    FN_SRLV:         dec_ctrl.alu_op = ALU_SRL;
                    FN_SRAV:         dec_ctrl.alu_op = ALU_SRA;
                    // fixed shifts take the amount from inst[10:6]
                    FN_SLL, FN_SRL, FN_SRA: begin
                        dec_ctrl.src1_sel = SRC1_SHAMT;
                        if (funct == FN_SLL) begin
                            dec_ctrl.alu_op = ALU_SLL;
                        end else if (funct == FN_SRL) begin
                            dec_ctrl.alu_op = ALU_SRL;
                        end else begin
                            dec_ctrl.alu_op = ALU_SRA;
                        end
                    end
                    FN_JR: begin
                        is_jump           = 1'b1;
                        dec_ctrl.rf_we    = 1'b0;
                        dec_ctrl.rf_waddr = '0;
                    end
                    default: begin
                        dec_ctrl.rf_we    = 1'b0;
                        dec_ctrl.rf_waddr = '0;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                dec_ctrl.src2_sel = SRC2_SIMM;
                dec_ctrl.rf_we    = 1'b1;
                dec_ctrl.rf_waddr = rt_addr;
                if (opcode == OP_SLTI) begin
                    dec_ctrl.alu_op = ALU_SLT;
                end else if (opcode == OP_SLTIU) begin
                    dec_ctrl.alu_op = ALU_SLTU;
                end else if (opcode == OP_LUI) begin
                    dec_ctrl.alu_op = ALU_LUI;
                end
            end
            // logic immediates are zero extended
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec_ctrl.src2_sel = SRC2_ZIMM;
                dec_ctrl.rf_we    = 1'b1;
                dec_ctrl.rf_waddr = rt_addr;
                if (opcode == OP_ANDI) begin
                    dec_ctrl.alu_op = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    dec_ctrl.alu_op = ALU_OR;
                end else begin
                    dec_ctrl.alu_op = ALU_XOR;
                end
            end
            OP_LW: begin
                dec_ctrl.src2_sel    = SRC2_SIMM;
                dec_ctrl.mem_en      = 1'b1;
                dec_ctrl.rf_we       = 1'b1;
                dec_ctrl.rf_waddr    = rt_addr;
                dec_ctrl.rf_from_mem = 1'b1;
            end
            OP_SW: begin
                dec_ctrl.src2_sel = SRC2_SIMM;
                dec_ctrl.mem_en   = 1'b1;
                dec_ctrl.mem_we   = 1'b1;
            end
            OP_BEQ: is_beq = 1'b1;
            OP_BNE: is_bne = 1'b1;
            OP_J:   is_jump = 1'b1;
            // link value is pc + 8, built in ex
            OP_JAL: begin
                is_jump           = 1'b1;
                dec_ctrl.src1_sel = SRC1_PC;
                dec_ctrl.src2_sel = SRC2_EIGHT;
                dec_ctrl.rf_we    = 1'b1;
                dec_ctrl.rf_waddr = LINK_REG;
            end
            default: ;
        endcase
    end

    // a bubble carries no control at all
    assign ctrl    = id_valid ? dec_ctrl : '0;
    assign br_kind = id_valid ? {is_jump, is_bne, is_beq} : 3'b000;

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile import mips_isa_pkg::*; (
    input  logic          clk,
    input  reg_addr_t     raddr [2],
    output word_t         rdata [2],
    fwd_if.wb_sink        fwd
);

    word_t regs [NUM_REGS];

    // write from wb, $zero is never touched
    always_ff @(posedge clk) begin
        if (fwd.wb_we && (fwd.wb_waddr != '0)) begin
            regs[fwd.wb_waddr] <= fwd.wb_wdata;
        end
    end

    // async read ports
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

//--- hdl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import mips_isa_pkg::*; (
    input  reg_addr_t addr,
    input  word_t     rf_data,
    fwd_if.sink       fwd,
    output word_t     value,
    output logic      ex_match
);

    logic addr_nz;
    logic mem_match;
    logic wb_match;

    // $zero is hardwired, nothing may override it
    assign addr_nz = (addr != '0);

    assign ex_match  = addr_nz && fwd.ex_we  && (fwd.ex_waddr  == addr);
    assign mem_match = addr_nz && fwd.mem_we && (fwd.mem_waddr == addr);
    assign wb_match  = addr_nz && fwd.wb_we  && (fwd.wb_waddr  == addr);

    // youngest result wins
    always_comb begin
        if (ex_match) begin
            value = fwd.ex_wdata;
        end else if (mem_match) begin
            value = fwd.mem_wdata;
        end else if (wb_match) begin
            value = fwd.wb_wdata;
        end else begin
            value = rf_data;
        end
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import mips_isa_pkg::*; (
    input  logic [2:0] br_kind,
    input  word_t      inst,
    input  word_t      id_pc,
    input  word_t      rs_value,
    input  word_t      rt_value,
    input  logic       rs_ex_match,
    input  logic       rt_ex_match,
    input  logic       ex_is_load,
    output logic       br_taken,
    output word_t      br_target,
    output logic       stall_load
);

    logic  is_beq;
    logic  is_bne;
    logic  is_jump;
    logic  is_jr;
    logic  ops_equal;
    word_t pc_plus_4;
    word_t rel_offset;

    assign {is_jump, is_bne, is_beq} = br_kind;

    // jr is the only jump coming from the special opcode
    assign is_jr = is_jump && (inst[31:26] == OP_SPECIAL);

    assign ops_equal  = (rs_value == rt_value);
    assign pc_plus_4  = id_pc + 32'd4;
    assign rel_offset = {{14{inst[15]}}, inst[15:0], 2'b00};

    assign br_taken = (is_beq && ops_equal) || (is_bne && !ops_equal) || is_jump;

    always_comb begin
        if (is_beq || is_bne) begin
            br_target = pc_plus_4 + rel_offset;
        end else if (is_jr) begin
            br_target = rs_value;
        end else if (is_jump) begin
            // stay inside the current 256 MB region
            br_target = {pc_plus_4[31:28], inst[25:0], 2'b00};
        end else begin
            br_target = '0;
        end
    end

    // load result not ready until mem, hold decode one cycle
    assign stall_load = ex_is_load && (rs_ex_match || rt_ex_match);

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  stall_t    stall,
    input  logic      if_valid,
    input  word_t     if_pc,
    input  word_t     inst_rdata,
    input  logic      ex_we,
    input  reg_addr_t ex_waddr,
    input  word_t     ex_wdata,
    input  logic      ex_is_load,
    input  logic      mem_we,
    input  reg_addr_t mem_waddr,
    input  word_t     mem_wdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata,
    output logic      id_valid,
    output word_t     id_pc,
    output word_t     id_inst,
    output id_ctrl_t  id_ctrl,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      br_taken,
    output word_t     br_target,
    output logic      stall_load
);

    reg_addr_t  src_addr [2];
    word_t      rf_rdata [2];
    word_t      src_value [2];
    logic       src_ex_match [2];
    logic [2:0] br_kind;

    fwd_if fwd ();

    assign fwd.ex_we     = ex_we;
    assign fwd.ex_waddr  = ex_waddr;
    assign fwd.ex_wdata  = ex_wdata;
    assign fwd.mem_we    = mem_we;
    assign fwd.mem_waddr = mem_waddr;
    assign fwd.mem_wdata = mem_wdata;
    assign fwd.wb_we     = wb_we;
    assign fwd.wb_waddr  = wb_waddr;
    assign fwd.wb_wdata  = wb_wdata;

    if_id_latch u_latch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .inst_rdata (inst_rdata),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .inst       (id_inst)
    );

    inst_decoder u_decoder (
        .inst     (id_inst),
        .id_valid (id_valid),
        .rs_addr  (src_addr[0]),
        .rt_addr  (src_addr[1]),
        .ctrl     (id_ctrl),
        .br_kind  (br_kind)
    );

    regfile u_regfile (
        .clk   (clk),
        .raddr (src_addr),
        .rdata (rf_rdata),
        .fwd   (fwd)
    );

    // port 0 is rs, port 1 is rt
    for (genvar i = 0; i < 2; i++) begin : g_bypass
        operand_bypass u_bypass (
            .addr     (src_addr[i]),
            .rf_data  (rf_rdata[i]),
            .fwd      (fwd),
            .value    (src_value[i]),
            .ex_match (src_ex_match[i])
        );
    end

    assign rs_value = src_value[0];
    assign rt_value = src_value[1];

    branch_unit u_branch (
        .br_kind     (br_kind),
        .inst        (id_inst),
        .id_pc       (id_pc),
        .rs_value    (src_value[0]),
        .rt_value    (src_value[1]),
        .rs_ex_match (src_ex_match[0]),
        .rt_ex_match (src_ex_match[1]),
        .ex_is_load  (ex_is_load),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .stall_load  (stall_load)
    );

endmodule

//--- verification/id_stage_assertions.sv
`timescale 1ns/1ps

module id_stage_checker import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input logic      clk,
    input logic      rst,
    input stall_t    stall,
    input logic      if_valid,
    input word_t     if_pc,
    input word_t     inst_rdata,
    input logic      ex_we,
    input reg_addr_t ex_waddr,
    input word_t     ex_wdata,
    input logic      ex_is_load,
    input logic      mem_we,
    input reg_addr_t mem_waddr,
    input word_t     mem_wdata,
    input logic      wb_we,
    input reg_addr_t wb_waddr,
    input word_t     wb_wdata,
    input logic      id_valid,
    input word_t     id_pc,
    input word_t     id_inst,
    input id_ctrl_t  id_ctrl,
    input word_t     rs_value,
    input word_t     rt_value,
    input logic      br_taken,
    input word_t     br_target,
    input logic      stall_load
);

    int        err_count = 0;
    logic      armed = 1'b0;
    logic      seen_valid = 1'b0;
    logic      held_mark = 1'b0;
    logic      ref_valid = 1'b0;
    word_t     ref_pc = '0;
    word_t     ref_word;
    word_t     exp_inst;
    word_t     shadow [NUM_REGS];
    reg_addr_t src [2];
    word_t     exp_src [2];
    opcode_t   opc;
    funct_t    fn;
    word_t     pc4;
    logic      is_br;
    logic      exp_taken;
    word_t     exp_target;
    logic      dec_known;
    id_ctrl_t  exp_ctrl;
    logic      exp_stall;

    // ************************************************************************
    // reference state
    // ************************************************************************
    always @(posedge clk) begin
        armed <= 1'b1;
        if (wb_we && wb_waddr != '0) begin
            shadow[wb_waddr] <= wb_wdata;
        end
        if (!rst && if_valid && !stall.id_hold) begin
            seen_valid <= 1'b1;
        end
        // expected IF/ID latch content
        if (rst) begin
            ref_valid <= 1'b0;
            ref_pc    <= '0;
        end else if (!stall.id_hold) begin
            ref_valid <= if_valid;
            ref_pc    <= if_pc;
        end else if (!stall.ex_hold) begin
            ref_valid <= 1'b0;
            ref_pc    <= '0;
        end
        // first cycle with both holds keeps the fetched word
        if (rst || !(stall.id_hold && stall.ex_hold)) begin
            held_mark <= 1'b0;
        end else if (!held_mark) begin
            held_mark <= 1'b1;
            ref_word  <= inst_rdata;
        end
    end

    assign exp_inst = held_mark ? ref_word : inst_rdata;
    assign opc      = exp_inst[31:26];
    assign fn       = exp_inst[5:0];
    assign src[0]   = exp_inst[25:21];
    assign src[1]   = exp_inst[20:16];
    assign pc4      = ref_pc + 32'd4;

    // EX over MEM over WB over the register file
    // $zero is never forwarded
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src[i] == '0) begin
                exp_src[i] = '0;
            end else if (ex_we && ex_waddr == src[i]) begin
                exp_src[i] = ex_wdata;
            end else if (mem_we && mem_waddr == src[i]) begin
                exp_src[i] = mem_wdata;
            end else if (wb_we && wb_waddr == src[i]) begin
                exp_src[i] = wb_wdata;
            end else begin
                exp_src[i] = shadow[src[i]];
            end
        end
    end

    always_comb begin
        is_br      = 1'b0;
        exp_taken  = 1'b0;
        exp_target = '0;
        if (opc == OP_BEQ || opc == OP_BNE) begin
            is_br      = 1'b1;
            exp_taken  = (opc == OP_BEQ) ? (exp_src[0] == exp_src[1])
                                         : (exp_src[0] != exp_src[1]);
            exp_target = pc4 + word_t'($signed(exp_inst[15:0])) * 4;
        end else if (opc == OP_J || opc == OP_JAL) begin
            is_br      = 1'b1;
            exp_taken  = 1'b1;
            exp_target = (pc4 & 32'hf000_0000) | (word_t'(exp_inst[25:0]) << 2);
        end else if (opc == OP_SPECIAL && fn == FN_JR) begin
            is_br      = 1'b1;
            exp_taken  = 1'b1;
            exp_target = exp_src[0];
        end
        is_br     = is_br && ref_valid;
        exp_taken = exp_taken && ref_valid;
    end

    // expected control for the decode checks
    always_comb begin
        dec_known = 1'b1;
        exp_ctrl  = '0;
        if (opc == OP_SPECIAL && fn == FN_ADD) begin
            exp_ctrl.rf_we    = 1'b1;
            exp_ctrl.rf_waddr = exp_inst[15:11];
        end else if (opc == OP_ORI) begin
            exp_ctrl.alu_op   = ALU_OR;
            exp_ctrl.src2_sel = SRC2_ZIMM;
            exp_ctrl.rf_we    = 1'b1;
            exp_ctrl.rf_waddr = exp_inst[20:16];
        end else if (opc == OP_LW) begin
            exp_ctrl.src2_sel    = SRC2_SIMM;
            exp_ctrl.mem_en      = 1'b1;
            exp_ctrl.rf_we       = 1'b1;
            exp_ctrl.rf_waddr    = exp_inst[20:16];
            exp_ctrl.rf_from_mem = 1'b1;
        end else if (opc == OP_SW) begin
            exp_ctrl.src2_sel = SRC2_SIMM;
            exp_ctrl.mem_en   = 1'b1;
            exp_ctrl.mem_we   = 1'b1;
        end else begin
            dec_known = 1'b0;
        end
    end

    assign exp_stall = ex_is_load && ex_we && ex_waddr != '0
                       && (ex_waddr == src[0] || ex_waddr == src[1]);

    // ************************************************************************
    // assertions
    // ************************************************************************
    a_reset_quiet: assert property (@(posedge clk) armed && !seen_valid |->
        id_valid === 1'b0 && id_ctrl.mem_en === 1'b0 && id_ctrl.mem_we === 1'b0
        && id_ctrl.rf_we === 1'b0 && br_taken === 1'b0 && stall_load === 1'b0)
        else begin
            err_count++;
            $error("Fail %0t reset outputs got valid %b ctrl %h taken %b stall %b exp 0",
                   $time, id_valid, id_ctrl, br_taken, stall_load);
        end

    a_latch: assert property (@(posedge clk) disable iff (rst)
        id_valid === ref_valid && id_pc === ref_pc)
        else begin
            err_count++;
            $error("Fail %0t id_valid id_pc got %b %h exp %b %h",
                   $time, id_valid, id_pc, ref_valid, ref_pc);
        end

    a_decode: assert property (@(posedge clk) disable iff (rst)
        ref_valid && dec_known |-> id_ctrl == exp_ctrl)
        else begin
            err_count++;
            $error("Fail %0t id_ctrl got %h exp %h", $time, id_ctrl, exp_ctrl);
        end

    a_rs_value: assert property (@(posedge clk) disable iff (rst)
        rs_value === exp_src[0])
        else begin
            err_count++;
            $error("Fail %0t rs_value got %h exp %h", $time, rs_value, exp_src[0]);
        end

    a_rt_value: assert property (@(posedge clk) disable iff (rst)
        rt_value === exp_src[1])
        else begin
            err_count++;
            $error("Fail %0t rt_value got %h exp %h", $time, rt_value, exp_src[1]);
        end

    a_stall_load: assert property (@(posedge clk) disable iff (rst)
        stall_load == exp_stall)
        else begin
            err_count++;
            $error("Fail %0t stall_load got %b exp %b", $time, stall_load, exp_stall);
        end

    a_br_taken: assert property (@(posedge clk) disable iff (rst)
        br_taken == exp_taken)
        else begin
            err_count++;
            $error("Fail %0t br_taken got %b exp %b", $time, br_taken, exp_taken);
        end

    a_br_target: assert property (@(posedge clk) disable iff (rst)
        is_br |-> br_target == exp_target)
        else begin
            err_count++;
            $error("Fail %0t br_target got %h exp %h", $time, br_target, exp_target);
        end

    a_hold_pc: assert property (@(posedge clk) disable iff (rst)
        stall.id_hold && stall.ex_hold |=> id_pc == $past(id_pc))
        else begin
            err_count++;
            $error("Fail %0t id_pc got %h exp %h", $time, id_pc, $past(id_pc));
        end

    a_hold_inst: assert property (@(posedge clk) disable iff (rst)
        held_mark |-> id_inst == ref_word)
        else begin
            err_count++;
            $error("Fail %0t id_inst got %h exp %h", $time, id_inst, ref_word);
        end

    a_bubble: assert property (@(posedge clk) disable iff (rst)
        stall.id_hold && !stall.ex_hold |=> !id_valid)
        else begin
            err_count++;
            $error("Fail %0t id_valid got %b exp 0", $time, id_valid);
        end

endmodule

bind id_stage id_stage_checker u_chk (.*);

//--- verification/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    // sum of all test lengths in cycles
    localparam int TEST_CYCLES = 96;

    logic      clk = 1'b0;
    logic      rst;
    stall_t    stall;
    logic      if_valid;
    word_t     if_pc;
    word_t     inst_rdata;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      ex_is_load;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    logic      id_valid;
    word_t     id_pc;
    word_t     id_inst;
    id_ctrl_t  id_ctrl;
    word_t     rs_value;
    word_t     rt_value;
    logic      br_taken;
    word_t     br_target;
    logic      stall_load;

    integer seed = 32'hda;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     errs_before = 0;
    word_t  pc = 32'h0040_0000;

    id_stage DUT (.*);

    always #10 clk = ~clk;

    initial begin
        #(TEST_CYCLES * 20 + 2000);
        $display("watchdog: simulation ran past its time limit");
        $display("Done: errors found");
        $finish;
    end

    // ************************************************************************
    // stimulus helpers
    // ************************************************************************
    task automatic issue(input word_t word);
        @(posedge clk);
        if_valid   <= 1'b1;
        if_pc      <= pc;
        inst_rdata <= word;
        pc = pc + 4;
        @(posedge clk);
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        wb_we    <= 1'b1;
        wb_waddr <= a;
        wb_wdata <= d;
        @(posedge clk);
        wb_we <= 1'b0;
    endtask

    task automatic clear_sources();
        @(posedge clk);
        ex_we      <= 1'b0;
        ex_is_load <= 1'b0;
        mem_we     <= 1'b0;
        wb_we      <= 1'b0;
    endtask

    task automatic close_test(input string name);
        int n;
        repeat (2) @(posedge clk);
        n = DUT.u_chk.err_count - errs_before;
        errs_before = DUT.u_chk.err_count;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %s %s (%0d assertion failures)", name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    initial begin
        word_t v;
        word_t eq_word;
        rst = 1'b1;
        stall = '0;
        if_valid = 1'b0;
        if_pc = '0;
        inst_rdata = '0;
        ex_we = 1'b0;
        ex_waddr = '0;
        ex_wdata = '0;
        ex_is_load = 1'b0;
        mem_we = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        wb_we = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;

        // hold reset and idle until the first fetch
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        for (int r = 1; r < 9; r++) begin
            v = $random(seed);
            write_reg(r[4:0], v);
            if (r == 2) begin
                eq_word = v;
            end
        end
        // equal pair for beq
        write_reg(5'd3, eq_word);
        close_test("reset");

        issue(r_type(5'd1, 5'd2, 5'd4, FN_ADD));
        issue(i_type(OP_ORI, 5'd1, 5'd5, 16'hbeef));
        issue(i_type(OP_LW, 5'd1, 5'd6, 16'h0008));
        issue(i_type(OP_SW, 5'd1, 5'd6, 16'h0004));
        close_test("decode");

        @(posedge clk);
        ex_we <= 1'b1;
        ex_waddr <= 5'd1;
        ex_wdata <= $random(seed);
        mem_we <= 1'b1;
        mem_waddr <= 5'd1;
        mem_wdata <= $random(seed);
        wb_we <= 1'b1;
        wb_waddr <= 5'd1;
        wb_wdata <= $random(seed);
        issue(r_type(5'd1, 5'd2, 5'd9, FN_ADD));
        @(posedge clk);
        ex_we <= 1'b0;
        issue(r_type(5'd1, 5'd2, 5'd9, FN_ADD));
        clear_sources();
        v = $random(seed);
        write_reg(5'd7, v);
        issue(r_type(5'd7, 5'd2, 5'd9, FN_ADD));
        @(posedge clk);
        ex_we <= 1'b1;
        ex_waddr <= 5'd0;
        ex_wdata <= $random(seed);
        issue(r_type(5'd0, 5'd0, 5'd9, FN_ADD));
        clear_sources();
        close_test("forwarding");

        @(posedge clk);
        ex_we <= 1'b1;
        ex_is_load <= 1'b1;
        ex_waddr <= 5'd2;
        ex_wdata <= $random(seed);
        issue(r_type(5'd1, 5'd2, 5'd9, FN_ADD));
        @(posedge clk);
        ex_waddr <= 5'd1;
        issue(r_type(5'd1, 5'd2, 5'd9, FN_ADD));
        @(posedge clk);
        ex_waddr <= 5'd12;
        issue(r_type(5'd1, 5'd2, 5'd9, FN_ADD));
        clear_sources();
        close_test("load_use");

        issue(i_type(OP_BEQ, 5'd2, 5'd3, 16'h0010));
        issue(i_type(OP_BNE, 5'd2, 5'd3, 16'hfff0));
        issue(i_type(OP_BEQ, 5'd1, 5'd2, 16'h0004));
        issue(i_type(OP_BNE, 5'd1, 5'd2, 16'h8000));
        issue({OP_J, 26'h123_4567});
        issue({OP_JAL, 26'h2ab_cdef});
        @(posedge clk);
        ex_we <= 1'b1;
        ex_waddr <= 5'd1;
        ex_wdata <= $random(seed);
        issue(r_type(5'd1, 5'd0, 5'd0, FN_JR));
        clear_sources();
        close_test("branches");

        issue(r_type(5'd4, 5'd5, 5'd10, FN_ADD));
        @(posedge clk);
        stall <= 2'b11;
        if_pc <= 32'h0bad_0000;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            inst_rdata <= $random(seed);
        end
        @(posedge clk);
        stall <= 2'b00;
        inst_rdata <= r_type(5'd1, 5'd2, 5'd11, FN_ADD);
        @(posedge clk);
        stall <= 2'b01;
        @(posedge clk);
        stall <= 2'b00;
        if_valid <= 1'b0;
        close_test("stall_hold");

        $display("tests %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, DUT.u_chk.err_count);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/mips_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/fwd_if.sv
hdl/if_id_latch.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
verification/id_stage_assertions.sv
verification/id_stage_tb.sv
